//--- rtl/map/levelMaps.mem
// One row of 20 tiles per line with column 0 in the leftmost hex digit
// Codes are 0 empty, 1 solid, 2 brick, 3 coin and 4 to 7 markers
// Level 0
00030000000000000000
00000000000000000000
01110000000000022200
00000000300000000000
00000222222000000000
00000000000000001000
00300000000000001000
00000000002000001000
00000000000000000000
00000022200000000300
00004000000000000000
00000000000000000000
00001111000001111000
00000000000000000000
10000000000000000001
// Level 1
00000000000000000000
00000000000000000000
00111100000001111100
00000000000000000000
00030000000000003000
00000000020000000000
00000000020000000000
00000000001000000000
00000000020000000000
00000000000000000000
02220000000000002220
00000000000000000000
00000050000000000000
00000000000000000000
30000000000000000000

//--- files.f
common/videoPkg.sv
common/gamePkg.sv
rtl/map/tileMap.sv
rtl/tank/tankMover.sv
rtl/pixelRenderer.sv
rtl/tankGameTop.sv
verif/tankGameTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tankGameTb
FILELIST = files.f
OBJDIR   = obj_dir
PASSTEXT = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- verif/tankGameTb.sv
`timescale 1ns/1ns

module tankGameTb
    import gamePkg::*;
    import videoPkg::*;
();

    localparam int  TankWidth   = 24;
    localparam time ClockPeriod = 100;
    localparam int  ResetCycles = 8;

    // Button order in a row is up, right, down, left
    localparam logic [3:0] BtnRight = 4'b0100;

    typedef enum logic [1:0]
    {
        OpProbe,
        OpFrame,
        OpReset
    } opKindT;

    typedef struct packed
    {
        logic       level;
        opKindT     op;
        pixelPosT   pixel;
        logic [3:0] buttons;
        logic [1:0] speed;
        logic       dispEna;
        rgbT        expColour;
        coinCountT  expCoins;
    } stimRowT;

    logic       Master_Clock_In;
    logic       arstN;
    logic       dispEna;
    pixelPosT   pixel;
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic       levelSelect;
    logic [1:0] speedSelect;
    rgbT        colour;
    coinCountT  coinValue;

    stimRowT   stimTable[$];
    logic      tableBuilt = 1'b0;
    int        resetCount = 0;

    // Reference game state that advances as rows are added
    int        modelX;
    int        modelY;
    coinCountT modelCoins;
    logic      modelLevel;
    logic      coinTaken;

    tankGameTop #(
        .TankWidth (TankWidth)
    ) tankGameTop_i (
        .Master_Clock_In (Master_Clock_In),
        .arstN           (arstN),
        .dispEna         (dispEna),
        .pixel           (pixel),
        .up              (up),
        .down            (down),
        .left            (left),
        .right           (right),
        .levelSelect     (levelSelect),
        .speedSelect     (speedSelect),
        .colour          (colour),
        .coinValue       (coinValue)
    );

    initial
    begin
        Master_Clock_In = 1'b0;
        forever
        begin
            #(ClockPeriod / 2);
            Master_Clock_In = ~Master_Clock_In;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model

    // Only the tiles that the probes and the coin path touch are modelled
    function automatic tileCodeT modelTile(input logic lvl, input int col, input int row);
        if (col == 10 && row == 7)
            return lvl ? TileSolid : TileBrick;
        if (col == 0 && row == 14)
            return lvl ? TileCoin : TileSolid;
        if (!lvl && col == 3 && row == 0 && !coinTaken)
            return TileCoin;
        return TileEmpty;
    endfunction

    function automatic rgbT modelColour(input pixelPosT p, input logic ena);
        int px;
        int py;
        px = int'(p.x);
        py = int'(p.y);
        if (!ena)
            return rgbT'(12'h000);
        if (px >= 640 || py >= 480)
            return rgbT'(12'h222);
        if (px > modelX && px < modelX + TankWidth && py > modelY && py < modelY + TankWidth)
            return rgbT'(12'h0A0);
        case (modelTile(modelLevel, px / 32, py / 32))
            TileSolid: return rgbT'(12'h444);
            TileBrick: return rgbT'(12'hA42);
            TileCoin:  return rgbT'(12'hFD0);
            default:   return rgbT'(12'hFFF);
        endcase
    endfunction

    // A coin under a corner takes the place of the move
    // The stimulus never brings the tank near a wall or an edge
    task automatic stepModel(input logic [3:0] buttons, input logic [1:0] speed);
        int cx;
        int cy;
        int step;
        step = 1 + int'(speed);
        for (int i = 0; i < 4; i++)
        begin
            cx = modelX + ((i % 2 == 1) ? TankWidth : 0);
            cy = modelY + ((i >= 2) ? TankWidth : 0);
            if (modelTile(modelLevel, (cx / 32) % 20, (cy / 32) % 15) == TileCoin)
            begin
                coinTaken  = 1'b1;
                modelCoins = modelCoins + 8'd1;
                return;
            end
        end
        if (buttons[3])
            modelY = modelY - step;
        else if (buttons[2])
            modelX = modelX + step;
        else if (buttons[1])
            modelY = modelY + step;
        else if (buttons[0])
            modelX = modelX - step;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table building

    task automatic addRow(input opKindT op, input int x, input int y, input logic ena,
                          input logic [3:0] buttons, input logic [1:0] speed);
        stimRowT row;
        row.level     = modelLevel;
        row.op        = op;
        row.pixel     = '{x: coordT'(x), y: coordT'(y)};
        row.buttons   = buttons;
        row.speed     = speed;
        row.dispEna   = ena;
        row.expColour = modelColour(row.pixel, ena);
        row.expCoins  = modelCoins;
        stimTable.push_back(row);
    endtask

    task automatic addReset(input logic lvl);
        modelLevel = lvl;
        modelX     = StartX;
        modelY     = StartY;
        modelCoins = '0;
        coinTaken  = 1'b0;
        resetCount++;
        addRow(OpReset, 0, 0, 1'b0, 4'b0000, 2'd0);
    endtask

    // Frame end sits on the first position past the visible area
    task automatic addFrames(input int count, input logic [3:0] buttons, input logic [1:0] speed);
        repeat (count)
        begin
            addRow(OpFrame, 640, 480, 1'b1, buttons, speed);
            stepModel(buttons, speed);
        end
    endtask

    task automatic addProbe(input int x, input int y, input logic ena);
        addRow(OpProbe, x, y, ena, 4'b0000, 2'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Driving and checking

    task automatic driveRow(input stimRowT row);
        arstN                   = (row.op != OpReset);
        levelSelect             = row.level;
        dispEna                 = row.dispEna;
        pixel                   = row.pixel;
        {up, right, down, left} = row.buttons;
        speedSelect             = row.speed;
    endtask

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkColour(input rgbT expected, input rgbT actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: colour expected %03h, actual %03h",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCoins(input coinCountT expected, input coinCountT actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: coinValue expected %0d, actual %0d",
                     $time, expected, actual);
            abortRun();
        end
    endtask

    initial
    begin
        wait (tableBuilt);
        #(ClockPeriod * (4 * stimTable.size() + ResetCycles * resetCount + 1));
        $display("Watchdog expired before all stimulus rows were applied");
        abortRun();
    end

    initial
    begin
        arstN       = 1'b0;
        dispEna     = 1'b0;
        pixel       = '0;
        up          = 1'b0;
        down        = 1'b0;
        left        = 1'b0;
        right       = 1'b0;
        levelSelect = 1'b0;
        speedSelect = 2'd0;

        // Level 1 tiles and movement at top speed
        addReset(1'b1);
        addProbe(330, 230, 1'b1);
        addProbe(10, 460, 1'b1);
        addFrames(3, BtnRight, 2'd3);
        addProbe(18, 15, 1'b1);
        addProbe(40, 15, 1'b1);
        addProbe(41, 15, 1'b1);

        // Level 0 blanking, tiles, tank box and the coin path
        addReset(1'b0);
        addProbe(15, 15, 1'b0);
        addProbe(640, 10, 1'b1);
        addProbe(330, 230, 1'b1);
        addProbe(10, 460, 1'b1);
        addProbe(15, 15, 1'b1);
        addProbe(5, 15, 1'b1);
        addProbe(120, 10, 1'b1);
        addFrames(17, BtnRight, 2'd3);
        addProbe(120, 10, 1'b1);
        addFrames(1, BtnRight, 2'd3);
        addProbe(74, 15, 1'b1);
        addFrames(1, BtnRight, 2'd3);
        addProbe(120, 10, 1'b1);
        addProbe(76, 15, 1'b1);
        addProbe(78, 15, 1'b1);

        // Fresh game brings the coin back
        addReset(1'b0);
        addProbe(120, 10, 1'b1);
        tableBuilt = 1'b1;

        @(negedge Master_Clock_In);
        foreach (stimTable[i])
        begin
            driveRow(stimTable[i]);
            repeat ((stimTable[i].op == OpReset) ? ResetCycles : 1)
                @(negedge Master_Clock_In);
            if (stimTable[i].op == OpProbe)
            begin
                checkColour(stimTable[i].expColour, colour);
                checkCoins(stimTable[i].expCoins, coinValue);
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- rtl/tankGameTop.sv
`timescale 1ns/1ns

module tankGameTop
    import gamePkg::*;
    import videoPkg::*;
#(
    parameter int TankWidth = 24
)
(
    input  logic       Master_Clock_In,
    input  logic       arstN,
    input  logic       dispEna,
    input  pixelPosT   pixel,
    input  logic       up,
    input  logic       down,
    input  logic       left,
    input  logic       right,
    input  logic       levelSelect,
    input  logic [1:0] speedSelect,
    output rgbT        colour,
    output coinCountT  coinValue
);

    cornerTilesT cornerPos;
    cornerCodesT cornerCode;
    logic        coinClear;
    tilePosT     clearPos;
    pixelPosT    tankPos;
    tilePosT     pixelTile;
    tileCodeT    pixelCode;

    // Level data and collected coins
    tileMap tileMap_i (
        .Master_Clock_In (Master_Clock_In),
        .arstN           (arstN),
        .levelSelect     (levelSelect),
        .cornerPos       (cornerPos),
        .coinClear       (coinClear),
        .clearPos        (clearPos),
        .pixelTile       (pixelTile),
        .cornerCode      (cornerCode),
        .pixelCode       (pixelCode)
    );

    // Once-per-frame game step
    tankMover #(
        .TankWidth (TankWidth)
    ) tankMover_i (
        .Master_Clock_In (Master_Clock_In),
        .arstN           (arstN),
        .dispEna         (dispEna),
        .pixel           (pixel),
        .up              (up),
        .down            (down),
        .left            (left),
        .right           (right),
        .speedSelect     (speedSelect),
        .cornerCode      (cornerCode),
        .cornerPos       (cornerPos),
        .coinClear       (coinClear),
        .clearPos        (clearPos),
        .tankPos         (tankPos),
        .coinValue       (coinValue)
    );

    pixelRenderer #(
        .TankWidth (TankWidth)
    ) pixelRenderer_i (
        .Master_Clock_In (Master_Clock_In),
        .arstN           (arstN),
        .dispEna         (dispEna),
        .pixel           (pixel),
        .tankPos         (tankPos),
        .pixelCode       (pixelCode),
        .pixelTile       (pixelTile),
        .colour          (colour)
    );

endmodule

//--- rtl/pixelRenderer.sv
`timescale 1ns/1ns

module pixelRenderer
    import gamePkg::*;
    import videoPkg::*;
#(
    parameter int TankWidth = 24
)
(
    input  logic     Master_Clock_In,
    input  logic     arstN,
    input  logic     dispEna,
    input  pixelPosT pixel,
    input  pixelPosT tankPos,
    input  tileCodeT pixelCode,
    output tilePosT  pixelTile,
    output rgbT      colour
);

    // Flat colours for the tank and each tile kind
    localparam rgbT TankColour    = '{red: 4'h0, green: 4'hA, blue: 4'h0};
    localparam rgbT EmptyColour   = '{red: 4'hF, green: 4'hF, blue: 4'hF};
    localparam rgbT SolidColour   = '{red: 4'h4, green: 4'h4, blue: 4'h4};
    localparam rgbT BrickColour   = '{red: 4'hA, green: 4'h4, blue: 4'h2};
    localparam rgbT CoinColour    = '{red: 4'hF, green: 4'hD, blue: 4'h0};
    localparam rgbT MarkerColour  = '{red: 4'hF, green: 4'h4, blue: 4'h4};
    localparam rgbT UnknownColour = '{red: 4'h8, green: 4'h8, blue: 4'h8};

    logic inTank;
    rgbT  tileColour;
    rgbT  nextColour;

    assign pixelTile = toTile(pixel.x, pixel.y);

    // Box edges themselves show the tile underneath
    assign inTank = (pixel.x > tankPos.x) && (pixel.x < tankPos.x + TankWidth) &&
                    (pixel.y > tankPos.y) && (pixel.y < tankPos.y + TankWidth);

    always_comb
    begin
        case (pixelCode)
            TileEmpty:                tileColour = EmptyColour;
            TileSolid:                tileColour = SolidColour;
            TileBrick:                tileColour = BrickColour;
            TileCoin:                 tileColour = CoinColour;
            4'd4, 4'd5, 4'd6, 4'd7:   tileColour = MarkerColour;
            default:                  tileColour = UnknownColour;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Colour priority and output register

    always_comb
    begin
        if (!dispEna)
            nextColour = BlankColour;
        else if (pixel.x >= coordT'(PixelsHoriz) || pixel.y >= coordT'(PixelsVert))
            nextColour = OutsideColour;
        else if (inTank)
            nextColour = TankColour;
        else
            nextColour = tileColour;
    end

    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
            colour <= BlankColour;
        else
            colour <= nextColour;
    end

endmodule

//--- rtl/tank/tankMover.sv
`timescale 1ns/1ns

module tankMover
    import gamePkg::*;
    import videoPkg::*;
#(
    parameter int TankWidth = 24
)
(
    input  logic        Master_Clock_In,
    input  logic        arstN,
    input  logic        dispEna,
    input  pixelPosT    pixel,
    input  logic        up,
    input  logic        down,
    input  logic        left,
    input  logic        right,
    input  logic [1:0]  speedSelect,
    input  cornerCodesT cornerCode,
    output cornerTilesT cornerPos,
    output logic        coinClear,
    output tilePosT     clearPos,
    output pixelPosT    tankPos,
    output coinCountT   coinValue
);

    // Screen edge limits for the wrap rule
    localparam coordT WrapHighX = coordT'(PixelsHoriz - TankWidth);
    localparam coordT WrapHighY = coordT'(PixelsVert - TankWidth);
    localparam coordT LandX     = coordT'(PixelsHoriz - TankWidth - 3);
    localparam coordT LandY     = coordT'(PixelsVert - TankWidth - 3);

    logic     frameEnd;
    coordT    rightX;
    coordT    bottomY;
    logic     wrapX;
    logic     wrapY;
    logic     wallHit;
    cornerT   wallCorner;
    logic     coinHit;
    cornerT   coinCorner;
    logic     takeCoin;
    coordT    speed;
    pixelPosT nextPos;

    // One step per frame, on the first position past the visible area
    assign frameEnd = dispEna && (pixel.x == coordT'(PixelsHoriz)) &&
                      (pixel.y == coordT'(PixelsVert));

    //////////////////////////////////////////////////////////////////////
    // Corner tiles

    assign rightX  = tankPos.x + coordT'(TankWidth);
    assign bottomY = tankPos.y + coordT'(TankWidth);

    assign cornerPos[CornerTl] = toTile(tankPos.x, tankPos.y);
    assign cornerPos[CornerTr] = toTile(rightX, tankPos.y);
    assign cornerPos[CornerBl] = toTile(tankPos.x, bottomY);
    assign cornerPos[CornerBr] = toTile(rightX, bottomY);

    // First wall and first coin corner in TL, TR, BL, BR order
    always_comb
    begin
        wallHit    = 1'b0;
        wallCorner = CornerTl;
        coinHit    = 1'b0;
        coinCorner = CornerTl;
        for (int i = 0; i < 4; i++)
        begin
            if (!wallHit && (cornerCode[i] == TileSolid || cornerCode[i] == TileBrick))
            begin
                wallHit    = 1'b1;
                wallCorner = cornerT'(i);
            end
            if (!coinHit && cornerCode[i] == TileCoin)
            begin
                coinHit    = 1'b1;
                coinCorner = cornerT'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Step selection

    assign wrapX    = (tankPos.x == '0) || (tankPos.x >= WrapHighX);
    assign wrapY    = (tankPos.y == '0) || (tankPos.y >= WrapHighY);
    assign takeCoin = !wrapX && !wrapY && !wallHit && coinHit;
    assign speed    = coordT'(speedSelect) + coordT'(1);

    always_comb
    begin
        nextPos = tankPos;
        if (wrapX || wrapY)
        begin
            if (tankPos.x == '0)
                nextPos.x = LandX;
            else if (tankPos.x >= WrapHighX)
                nextPos.x = coordT'(3);
            if (tankPos.y == '0)
                nextPos.y = LandY;
            else if (tankPos.y >= WrapHighY)
                nextPos.y = coordT'(3);
        end
        else if (wallHit)
        begin
            // Diagonal nudge away from the blocked corner
            nextPos.x = wallCorner[0] ? tankPos.x - coordT'(1) : tankPos.x + coordT'(1);
            nextPos.y = wallCorner[1] ? tankPos.y - coordT'(1) : tankPos.y + coordT'(1);
        end
        else if (!coinHit)
        begin
            if (up)
                nextPos.y = tankPos.y - speed;
            else if (right)
                nextPos.x = tankPos.x + speed;
            else if (down)
                nextPos.y = tankPos.y + speed;
            else if (left)
                nextPos.x = tankPos.x - speed;
        end
    end

    // Tile is marked on the same edge that counts the coin
    assign coinClear = frameEnd && takeCoin;
    assign clearPos  = cornerPos[coinCorner];

    //////////////////////////////////////////////////////////////////////
    // Game state

    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
        begin
            tankPos   <= '{x: coordT'(StartX), y: coordT'(StartY)};
            coinValue <= '0;
        end
        else if (frameEnd)
        begin
            tankPos <= nextPos;
            if (takeCoin)
                coinValue <= coinValue + coinCountT'(1);
        end
    end

endmodule

//--- rtl/map/tileMap.sv
`timescale 1ns/1ns

module tileMap
    import gamePkg::*;
(
    input  logic        Master_Clock_In,
    input  logic        arstN,
    input  logic        levelSelect,
    input  cornerTilesT cornerPos,
    input  logic        coinClear,
    input  tilePosT     clearPos,
    input  tilePosT     pixelTile,
    output cornerCodesT cornerCode,
    output tileCodeT    pixelCode
);

    // 4 bits per tile, column 0 in the top nibble of the row word
    localparam int    RowBits   = 4 * MapCols;
    localparam int    MaskBits  = MapCols * MapRows;
    localparam string LevelFile = "rtl/map/levelMaps.mem";

    //////////////////////////////////////////////////////////////////////
    // Level storage

    // Level 0 rows 0 to 14 come first in the file, then level 1
    logic [RowBits-1:0] levelRom [0:2*MapRows-1];

    initial
    begin
        $readmemh(LevelFile, levelRom);
    end

    logic level;
    logic levelLocked;

    // Follows the switch while held in reset, frozen from the first edge after release
    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
            levelLocked <= 1'b0;
        else
            levelLocked <= 1'b1;
    end

    always_ff @(posedge Master_Clock_In)
    begin
        if (!levelLocked)
            level <= levelSelect;
    end

    //////////////////////////////////////////////////////////////////////
    // Collected coins

    // One bit per tile, indexed row * 20 + col
    logic [MaskBits-1:0] cleared;

    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
        begin
            cleared <= '0;
        end
        else if (coinClear)
        begin
            cleared[MapCols * int'(clearPos.row) + int'(clearPos.col)] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports

    function automatic tileCodeT readTile(input tilePosT pos);
        logic [RowBits-1:0] rowWord;
        rowWord = levelRom[MapRows * int'(level) + int'(pos.row)];
        if (cleared[MapCols * int'(pos.row) + int'(pos.col)])
            return TileEmpty;
        return tileCodeT'(rowWord[RowBits - 1 - 4 * int'(pos.col) -: 4]);
    endfunction

    // Four tank corners plus the raster pixel
    always_comb
    begin
        pixelCode = readTile(pixelTile);
        for (int i = 0; i < 4; i++)
        begin
            cornerCode[i] = readTile(cornerPos[i]);
        end
    end

endmodule

//--- common/gamePkg.sv
package gamePkg;

    // Map grid, each tile is 32 pixels square
    localparam int MapCols   = 20;
    localparam int MapRows   = 15;
    localparam int TileShift = 5;

    // Codes 4 to 7 are markers, anything above is unknown
    typedef enum logic [3:0]
    {
        TileEmpty = 4'd0,
        TileSolid = 4'd1,
        TileBrick = 4'd2,
        TileCoin  = 4'd3
    } tileCodeT;

    typedef struct packed
    {
        logic [4:0] col;
        logic [3:0] row;
    } tilePosT;

    // Bit 0 set means right edge, bit 1 set means bottom edge
    typedef enum logic [1:0]
    {
        CornerTl = 2'd0,
        CornerTr = 2'd1,
        CornerBl = 2'd2,
        CornerBr = 2'd3
    } cornerT;

    typedef tilePosT  [3:0] cornerTilesT;
    typedef tileCodeT [3:0] cornerCodesT;

    typedef logic [7:0] coinCountT;

    // Tank position after reset
    localparam int StartX = 5;
    localparam int StartY = 5;

    // Screen coordinate to tile, wrapping on the grid size
    function automatic tilePosT toTile(input logic [9:0] x, input logic [9:0] y);
        tilePosT pos;
        pos.col = 5'((x >> TileShift) % MapCols);
        pos.row = 4'((y >> TileShift) % MapRows);
        return pos;
    endfunction

endpackage

//--- common/videoPkg.sv
package videoPkg;

    // Visible raster size
    localparam int PixelsHoriz = 640;
    localparam int PixelsVert  = 480;

    // One screen coordinate, wide enough for the full 640 column count
    typedef logic [9:0] coordT;

    typedef struct packed
    {
        coordT x;
        coordT y;
    } pixelPosT;

    // 4 bits per channel, red in the top nibble
    typedef struct packed
    {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // Black during blanking, dark grey beyond the visible area
    localparam rgbT BlankColour   = '{red: 4'h0, green: 4'h0, blue: 4'h0};
    localparam rgbT OutsideColour = '{red: 4'h2, green: 4'h2, blue: 4'h2};

endpackage
